// ==== build.f ====
verilog/arm_core_pkg.sv
verilog/instr_decoder.sv
verilog/barrel_shifter.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/arm_core.sv
verification/clock_gen.sv
verification/arm_core_properties.sv
verification/arm_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arm_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module arm_core_tb -o arm_core_sim \
  && ./obj_dir/arm_core_sim \
  || exit 1

// ==== verification/arm_core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module arm_core_tb;
  import arm_core_pkg::*;

  logic  clk;
  logic  gen_reset;
  logic  test_reset;
  logic  core_reset;
  word_t mem_addr;
  logic  mem_read;
  logic  mem_write;
  word_t mem_wdata;
  word_t mem_rdata = '0;

  word_t mem [256];
  word_t read_log[$];
  word_t store_addr_q[$];
  word_t store_data_q[$];
  int    read_base;
  int    store_base;

  word_t prog[$];
  word_t data_addr[$];
  word_t data_val[$];
  word_t exp_addr[$];
  word_t exp_data[$];

  word_t rng_state = 32'h6051_0a68;

  assign core_reset = gen_reset | test_reset;

  clock_gen u_clock (.clk(clk), .reset(gen_reset));

  arm_core uut (
    .clk(clk), .reset(core_reset), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
    .mem_read(mem_read), .mem_write(mem_write), .mem_wdata(mem_wdata)
  );

  bind arm_core arm_core_properties props (
    .clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write)
  );

  // ========================================
  // Memory model
  // ========================================
  always begin : bus_model
    logic  pending;
    word_t paddr;
    @(negedge clk);
    pending = mem_read;
    paddr   = mem_addr;
    if (mem_read) read_log.push_back(mem_addr);
    if (mem_write) begin
      store_addr_q.push_back(mem_addr);
      store_data_q.push_back(mem_wdata);
    end
    @(posedge clk);
    #2;
    if (pending) mem_rdata = mem[paddr[9:2]];  // Valid one cycle after the strobe
  end

  // ========================================
  // Failure reporting and checks
  // ========================================
  task automatic stop_on_failure(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string what, word_t got, word_t expected);
    if (got !== expected) begin
      stop_on_failure($sformatf("** Error at %0t: %s got %h expected %h",
                                $time, what, got, expected));
    end
  endtask

  function automatic word_t xorshift32(word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output word_t r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // ========================================
  // Reference model
  // ========================================
  function automatic word_t rotate_right(word_t x, int n);
    int k;
    k = n % 32;
    if (k == 0) return x;
    return (x >> k) | (x << (32 - k));
  endfunction

  function automatic word_t imm_value(logic [3:0] rot, logic [7:0] imm8);
    return rotate_right({24'd0, imm8}, 2 * int'(rot));
  endfunction

  // Returns {carry, value}
  function automatic logic [32:0] shift_value(word_t v, logic [1:0] sh, logic [4:0] amt,
                                              logic cin);
    int k;
    k = int'(amt);
    case (sh)
      SH_LSL: return (k == 0) ? {cin, v} : {v[32 - k], v << k};
      SH_LSR: return (k == 0) ? {v[31], 32'd0} : {v[k - 1], v >> k};
      SH_ASR: return (k == 0) ? {v[31], {32{v[31]}}} : {v[k - 1], word_t'($signed(v) >>> k)};
      default: return (k == 0) ? {v[0], cin, v[31:1]} : {v[k - 1], rotate_right(v, k)};
    endcase
  endfunction

  // Returns {N, Z, C, V, result}
  function automatic logic [35:0] model_alu(logic [3:0] op, word_t a, word_t b, logic shc,
                                            logic [3:0] f);
    word_t r;
    logic  c;
    logic  v;
    c = shc;
    v = f[0];
    case (op)
      OP_AND, OP_TST: r = a & b;
      OP_EOR, OP_TEQ: r = a ^ b;
      OP_SUB, OP_CMP: begin
        r = a - b;
        c = (a >= b);
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      OP_RSB: begin
        r = b - a;
        c = (b >= a);
        v = (a[31] != b[31]) && (r[31] != b[31]);
      end
      OP_ADD, OP_CMN: begin
        {c, r} = {1'b0, a} + {1'b0, b};
        v = (a[31] == b[31]) && (r[31] != a[31]);
      end
      OP_ORR: r = a | b;
      OP_MOV: r = b;
      OP_BIC: r = a & ~b;
      default: r = ~b;
    endcase
    return {r[31], r == 32'd0, c, v, r};
  endfunction

  function automatic logic cond_holds(logic [3:0] cond, logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      COND_EQ: return z;
      COND_NE: return !z;
      COND_CS: return c;
      COND_CC: return !c;
      COND_MI: return n;
      COND_GE: return n == v;
      COND_LT: return n != v;
      COND_HI: return c && !z;
      COND_LS: return !c || z;
      default: return 1'b1;
    endcase
  endfunction

  // ========================================
  // Instruction encoding and program runs
  // ========================================
  function automatic word_t enc_dp_imm(logic [3:0] cond, logic [3:0] op, logic s,
                                       logic [3:0] rn, logic [3:0] rd, logic [3:0] rot,
                                       logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic word_t enc_dp_reg(logic [3:0] cond, logic [3:0] op, logic s,
                                       logic [3:0] rn, logic [3:0] rd, logic [4:0] amt,
                                       logic [1:0] sh, logic [3:0] rm);
    return {cond, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
  endfunction

  function automatic word_t enc_sdt(logic [3:0] cond, logic load, logic up, logic [3:0] rn,
                                    logic [3:0] rd, logic [11:0] off);
    return {cond, 2'b01, 1'b0, 1'b1, up, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  task automatic start_program;
    prog.delete();
    data_addr.delete();
    data_val.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic place_data(logic [11:0] addr, word_t value);
    data_addr.push_back({20'd0, addr});
    data_val.push_back(value);
  endtask

  // R0 stays zero, so [R0, #addr] is an absolute address
  task automatic load_reg(logic [3:0] rd, logic [11:0] addr, word_t value);
    place_data(addr, value);
    prog.push_back(enc_sdt(COND_AL, 1'b1, 1'b1, 4'd0, rd, addr));
  endtask

  task automatic store_reg(logic [3:0] rd, logic [11:0] addr, word_t expected);
    prog.push_back(enc_sdt(COND_AL, 1'b0, 1'b1, 4'd0, rd, addr));
    exp_addr.push_back({20'd0, addr});
    exp_data.push_back(expected);
  endtask

  task automatic wait_store(word_t addr, output word_t data);
    for (int cycle = 0; cycle < 2000; cycle++) begin
      for (int i = store_base; i < store_addr_q.size(); i++) begin
        if (store_addr_q[i] == addr) begin
          data = store_data_q[i];
          return;
        end
      end
      @(posedge clk);
    end
    stop_on_failure($sformatf("Timeout waiting for a store to address %h", addr));
  endtask

  function automatic logic store_seen(word_t addr);
    for (int i = store_base; i < store_addr_q.size(); i++) begin
      if (store_addr_q[i] == addr) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic run_program;
    word_t got;
    prog.push_back(enc_dp_imm(COND_AL, OP_SUB, 1'b0, 4'd15, 4'd15, 4'd0, 8'd8));  // Spin
    @(posedge clk);
    #2;
    test_reset = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hF000_0000 | (i << 2);  // NV condition never executes
    end
    foreach (prog[i]) mem[i] = prog[i];
    foreach (data_addr[i]) mem[data_addr[i][9:2]] = data_val[i];
    repeat (3) @(posedge clk);
    read_base  = read_log.size();
    store_base = store_addr_q.size();
    #2;
    test_reset = 1'b0;
    foreach (exp_addr[i]) begin
      wait_store(exp_addr[i], got);
      check_value($sformatf("store to %h", exp_addr[i]), got, exp_data[i]);
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_reset_state;
    start_program();
    prog.push_back(enc_dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'h5a));
    store_reg(4'd1, 12'h300, 32'h5a);
    run_program();
    if (read_log.size() <= read_base) stop_on_failure("no fetch after reset");
    check_value("first fetch address", read_log[read_base], 32'd0);
    check_value("first store address", store_addr_q[store_base], 32'h300);
  endtask

  task automatic test_immediates;
    logic [3:0] ops [6] = '{OP_ORR, OP_EOR, OP_BIC, OP_SUB, OP_RSB, OP_MVN};
    word_t a;
    word_t b;
    word_t r;
    next_random(a);
    next_random(b);
    next_random(r);
    start_program();
    load_reg(4'd1, 12'h200, a);
    load_reg(4'd2, 12'h204, b);
    prog.push_back(enc_dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd3, 4'd4, 8'hab));
    store_reg(4'd3, 12'h300, imm_value(4'd4, 8'hab));
    prog.push_back(enc_dp_imm(COND_AL, OP_ADD, 1'b0, 4'd1, 4'd4, 4'd15, 8'h3f));
    store_reg(4'd4, 12'h304, a + imm_value(4'd15, 8'h3f));
    foreach (ops[k]) begin
      prog.push_back(enc_dp_reg(COND_AL, ops[k], 1'b0, 4'd1, 4'd5, 5'd0, SH_LSL, 4'd2));
      store_reg(4'd5, 12'h308 + 12'(4 * k), word_t'(model_alu(ops[k], a, b, 1'b0, 4'd0)));
    end
    prog.push_back(enc_dp_imm(COND_AL, OP_EOR, 1'b0, 4'd1, 4'd6, r[11:8], r[7:0]));
    store_reg(4'd6, 12'h320, a ^ imm_value(r[11:8], r[7:0]));
    run_program();
  endtask

  task automatic test_shifts;
    logic [1:0] sh [8] = '{SH_LSL, SH_LSL, SH_LSR, SH_LSR, SH_ASR, SH_ASR, SH_ROR, SH_ROR};
    logic [4:0] amt [8] = '{5'd5, 5'd0, 5'd7, 5'd0, 5'd3, 5'd0, 5'd9, 5'd0};
    word_t a;
    word_t b;
    next_random(a);
    next_random(b);
    a = a | 32'h8000_0000;
    b = b & 32'h7fff_ffff;
    start_program();
    load_reg(4'd1, 12'h200, a);
    load_reg(4'd2, 12'h204, b);
    foreach (sh[k]) begin  // Flags are zero here, so RRX shifts in 0
      prog.push_back(enc_dp_reg(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd3, amt[k], sh[k], 4'd1));
      store_reg(4'd3, 12'h300 + 12'(4 * k), word_t'(shift_value(a, sh[k], amt[k], 1'b0)));
    end
    prog.push_back(enc_dp_reg(COND_AL, OP_CMP, 1'b1, 4'd0, 4'd0, 5'd0, SH_LSL, 4'd0));
    prog.push_back(enc_dp_reg(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd4, 5'd0, SH_ROR, 4'd2));
    store_reg(4'd4, 12'h340, word_t'(shift_value(b, SH_ROR, 5'd0, 1'b1)));
    prog.push_back(enc_dp_reg(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd4, 5'd0, SH_ASR, 4'd2));
    store_reg(4'd4, 12'h344, word_t'(shift_value(b, SH_ASR, 5'd0, 1'b1)));
    run_program();
  endtask

  task automatic flag_case(logic [3:0] op, word_t a, word_t b);
    logic [3:0] conds [9] = '{COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_GE,
                              COND_LT, COND_HI, COND_LS};
    logic [35:0] m;
    m = model_alu(op, a, b, 1'b0, 4'd0);
    start_program();
    load_reg(4'd1, 12'h200, a);
    load_reg(4'd2, 12'h204, b);
    prog.push_back(enc_dp_reg(COND_AL, op, 1'b1, 4'd1, 4'd3, 5'd0, SH_LSL, 4'd2));
    if (op == OP_ADD || op == OP_SUB) store_reg(4'd3, 12'h340, m[31:0]);
    foreach (conds[k]) begin
      prog.push_back(enc_sdt(conds[k], 1'b0, 1'b1, 4'd0, 4'd1, 12'h300 + 12'(4 * k)));
      if (cond_holds(conds[k], m[35:32])) begin
        exp_addr.push_back(32'h300 + 32'(4 * k));
        exp_data.push_back(a);
      end
    end
    store_reg(4'd1, 12'h3f0, a);
    run_program();
    // Failed conditions must leave no trace on the bus
    foreach (conds[k]) begin
      check_value($sformatf("store under condition %h", conds[k]),
                  {31'd0, store_seen(32'h300 + 32'(4 * k))},
                  {31'd0, cond_holds(conds[k], m[35:32])});
    end
  endtask

  task automatic test_flags;
    logic [3:0] ops [6] = '{OP_CMP, OP_CMN, OP_TST, OP_TEQ, OP_ADD, OP_SUB};
    word_t a;
    word_t b;
    foreach (ops[k]) begin
      next_random(a);
      next_random(b);
      flag_case(ops[k], a, b);
      flag_case(ops[k], a, a);
    end
  endtask

  task automatic test_ldr;
    logic [3:0]  rn [7] = '{4'd0, 4'd0, 4'd0, 4'd0, 4'd5, 4'd5, 4'd5};
    logic        up [7] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    logic [11:0] off [7] = '{12'h204, 12'h205, 12'h206, 12'h207, 12'h100, 12'h0fd, 12'h0fa};
    word_t d0;
    word_t d1;
    word_t addr;
    word_t base;
    next_random(d0);
    next_random(d1);
    start_program();
    place_data(12'h200, d0);
    place_data(12'h204, d1);
    prog.push_back(enc_dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd5, 4'd12, 8'h03));  // 0x300
    foreach (rn[k]) begin
      base = (rn[k] == 4'd5) ? 32'h300 : 32'd0;
      addr = up[k] ? base + {20'd0, off[k]} : base - {20'd0, off[k]};
      prog.push_back(enc_sdt(COND_AL, 1'b1, up[k], rn[k], 4'd6, off[k]));
      store_reg(4'd6, 12'h380 + 12'(4 * k),
                rotate_right(addr[2] ? d1 : d0, 8 * int'(addr[1:0])));
    end
    run_program();
  endtask

  task automatic test_pc;
    int idx;
    start_program();
    prog.push_back(enc_dp_reg(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd1, 5'd0, SH_LSL, 4'd15));
    store_reg(4'd1, 12'h300, 32'h8);
    prog.push_back(enc_dp_imm(COND_AL, OP_ADD, 1'b0, 4'd15, 4'd2, 4'd0, 8'h04));
    store_reg(4'd2, 12'h304, 32'h14);
    prog.push_back(enc_dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd15, 4'd0, 8'h40));
    while (prog.size() < 16) prog.push_back(32'hF000_0000);
    store_reg(4'd15, 12'h308, 32'h48);  // At 0x40
    run_program();
    idx = -1;
    for (int i = read_base; i < read_log.size(); i++) begin
      if (idx < 0 && read_log[i] == 32'h10) idx = i;
    end
    if (idx < 0 || idx + 1 >= read_log.size()) stop_on_failure("redirect fetch not seen");
    check_value("fetch after MOV R15", read_log[idx + 1], 32'h40);
  endtask

  initial begin
    test_reset = 1'b1;
    read_base  = 0;
    store_base = 0;
    test_reset_state();
    test_immediates();
    test_shifts();
    test_flags();
    test_ldr();
    test_pc();
    if (uut.props.failures != 0) begin
      stop_on_failure("a bus property assertion failed during the run");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/arm_core_properties.sv ====
`default_nettype none
`timescale 1ns/100ps

module arm_core_properties (
  input wire logic clk,
  input wire logic reset,
  input wire logic mem_read,
  input wire logic mem_write
);

  int unsigned failures = 0;  // Failed assertion count

  a_strobes_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
    else begin
      $error("mem_read and mem_write high together");
      failures++;
    end

  // One cycle after reset is seen the bus must be quiet
  a_quiet_in_reset: assert property (@(posedge clk) reset |=> !mem_read && !mem_write)
    else begin
      $error("bus strobe during reset");
      failures++;
    end

  a_write_one_cycle: assert property (
    @(posedge clk) disable iff (reset) mem_write |=> !mem_write)
    else begin
      $error("mem_write longer than one cycle");
      failures++;
    end

  a_no_back_to_back_read: assert property (
    @(posedge clk) disable iff (reset) mem_read |=> !mem_read)
    else begin
      $error("mem_read in two consecutive cycles");
      failures++;
    end

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verilog/arm_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module arm_core #(
  parameter arm_core_pkg::word_t RESET_PC = 32'd0
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire arm_core_pkg::word_t mem_rdata,
  output arm_core_pkg::word_t      mem_addr,
  output logic                     mem_read,
  output logic                     mem_write,
  output arm_core_pkg::word_t      mem_wdata
);
  import arm_core_pkg::*;

  instr_u      ir_q;
  logic [3:0]  flags_q;   // N Z C V
  word_t       rdata_q;   // Rotated load data

  logic        cond_pass;
  logic        is_transfer;
  logic        is_load;
  logic        imm_operand;
  logic        set_flags;
  logic [3:0]  opcode;
  logic [3:0]  rn;
  logic [3:0]  rd;
  logic [3:0]  rm;
  logic [11:0] operand2;
  logic [11:0] offset12;

  word_t       rn_raw;
  word_t       rm_raw;
  word_t       rd_raw;
  word_t       pc;
  word_t       rn_value;
  word_t       rm_value;
  word_t       shifter_out;
  logic        shifter_carry;
  word_t       op_b;
  word_t       alu_result;
  logic [3:0]  flags_out;
  logic        writes_result;

  logic        ir_load;
  logic        pc_incr;
  logic        result_we;
  logic        flags_we;
  logic        load_we;
  logic        addr_from_alu;

  logic        rf_we;
  word_t       rf_wdata;
  word_t       next_pc;

  // PC already advanced once, so R15 reads as instruction + 8
  function automatic word_t read_adjust(logic [3:0] sel, word_t value);
    return (sel == 4'd15) ? value + 32'd4 : value;
  endfunction

  instr_decoder u_decoder (
    .ir(ir_q), .flags(flags_q), .cond_pass(cond_pass), .is_transfer(is_transfer),
    .is_load(is_load), .imm_operand(imm_operand), .set_flags(set_flags), .up_offset(),
    .opcode(opcode), .rn(rn), .rd(rd), .rm(rm), .operand2(operand2), .offset12(offset12)
  );

  barrel_shifter u_shifter (
    .operand2(operand2), .imm_operand(imm_operand), .rm_value(rm_value),
    .carry_in(flags_q[FLAG_C]), .shifter_out(shifter_out), .shifter_carry(shifter_carry)
  );

  alu u_alu (
    .opcode(opcode), .op_a(rn_value), .op_b(op_b), .shifter_carry(shifter_carry),
    .flags_in(flags_q), .result(alu_result), .flags_out(flags_out),
    .writes_result(writes_result)
  );

  control_unit u_control (
    .clk(clk), .reset(reset), .is_transfer(is_transfer), .is_load(is_load),
    .cond_pass(cond_pass), .mem_read(mem_read), .mem_write(mem_write), .ir_load(ir_load),
    .pc_incr(pc_incr), .result_we(result_we), .flags_we(flags_we), .load_we(load_we),
    .addr_from_alu(addr_from_alu)
  );

  reg_file #(.RESET_PC(RESET_PC)) u_regs (
    .clk(clk), .reset(reset), .ra_sel(rn), .rb_sel(rm), .rc_sel(rd), .we(rf_we),
    .wsel(rd), .wdata(rf_wdata), .pc_incr(pc_incr), .ra(rn_raw), .rb(rm_raw), .rc(rd_raw),
    .pc(pc)
  );

  // ========================================
  // Operands and write-back
  // ========================================
  assign rn_value  = read_adjust(rn, rn_raw);
  assign rm_value  = read_adjust(rm, rm_raw);
  assign mem_wdata = read_adjust(rd, rd_raw);
  assign op_b      = is_transfer ? {20'd0, offset12} : shifter_out;  // Transfer offset

  assign rf_we    = (result_we && writes_result) || load_we;
  assign rf_wdata = load_we ? rdata_q : alu_result;

  always_comb begin
    if (rf_we && rd == 4'd15) begin
      next_pc = rf_wdata;  // Redirect
    end else if (pc_incr) begin
      next_pc = pc + 32'd4;
    end else begin
      next_pc = pc;
    end
  end

  // Address register follows the PC except while a transfer owns the bus
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_addr <= RESET_PC;
    end else if (addr_from_alu) begin
      mem_addr <= alu_result;
    end else begin
      mem_addr <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags_q <= 4'd0;
    end else if (flags_we && set_flags) begin
      flags_q <= flags_out;
    end
  end

  // Read data sampled every cycle, used only in WB
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_q <= mem_rdata;
    end
    rdata_q <= ror32(mem_rdata, {mem_addr[1:0], 3'b000});
  end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module reg_file #(
  parameter arm_core_pkg::word_t RESET_PC = 32'd0
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic [3:0]          ra_sel,
  input  wire logic [3:0]          rb_sel,
  input  wire logic [3:0]          rc_sel,
  input  wire logic                we,
  input  wire logic [3:0]          wsel,
  input  wire arm_core_pkg::word_t wdata,
  input  wire logic                pc_incr,
  output arm_core_pkg::word_t      ra,
  output arm_core_pkg::word_t      rb,
  output arm_core_pkg::word_t      rc,
  output arm_core_pkg::word_t      pc
);
  import arm_core_pkg::*;

  word_t regs [16];

  assign ra = regs[ra_sel];
  assign rb = regs[rb_sel];
  assign rc = regs[rc_sel];
  assign pc = regs[15];  // R15 is the PC

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= 32'd0;
      end
      regs[15] <= RESET_PC;
    end else begin
      if (we) begin
        regs[wsel] <= wdata;
      end
      // Result write to R15 wins over the increment
      if (pc_incr && !(we && wsel == 4'd15)) begin
        regs[15] <= regs[15] + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module control_unit (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic is_transfer,
  input  wire logic is_load,
  input  wire logic cond_pass,
  output logic      mem_read,
  output logic      mem_write,
  output logic      ir_load,
  output logic      pc_incr,
  output logic      result_we,
  output logic      flags_we,
  output logic      load_we,
  output logic      addr_from_alu
);

  localparam logic [2:0] ST_IDLE  = 3'd0;  // Only left after reset
  localparam logic [2:0] ST_FETCH = 3'd1;
  localparam logic [2:0] ST_LATCH = 3'd2;
  localparam logic [2:0] ST_EXEC  = 3'd3;
  localparam logic [2:0] ST_MEM   = 3'd4;
  localparam logic [2:0] ST_WAIT  = 3'd5;
  localparam logic [2:0] ST_WB    = 3'd6;

  logic [2:0] state;
  logic [2:0] next_state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ========================================
  // Next state and strobes
  // ========================================
  always_comb begin
    next_state    = ST_FETCH;
    mem_read      = 1'b0;
    mem_write     = 1'b0;
    ir_load       = 1'b0;
    pc_incr       = 1'b0;
    result_we     = 1'b0;
    flags_we      = 1'b0;
    load_we       = 1'b0;
    addr_from_alu = 1'b0;
    case (state)
      ST_FETCH: begin
        mem_read   = 1'b1;
        pc_incr    = 1'b1;
        next_state = ST_LATCH;
      end
      ST_LATCH: begin
        ir_load    = 1'b1;
        next_state = ST_EXEC;
      end
      ST_EXEC: begin
        if (cond_pass && is_transfer) begin
          addr_from_alu = 1'b1;  // Capture Rn +/- offset
          next_state    = ST_MEM;
        end else if (cond_pass) begin
          result_we = 1'b1;
          flags_we  = 1'b1;
        end
      end
      ST_MEM: begin
        mem_read      = is_load;
        mem_write     = !is_load;
        addr_from_alu = is_load;  // Hold address for the rotate in WAIT
        next_state    = is_load ? ST_WAIT : ST_FETCH;
      end
      ST_WAIT: next_state = ST_WB;
      ST_WB: load_we = 1'b1;
      default: next_state = ST_FETCH;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu (
  input  wire logic [3:0]          opcode,
  input  wire arm_core_pkg::word_t op_a,
  input  wire arm_core_pkg::word_t op_b,
  input  wire logic                shifter_carry,
  input  wire logic [3:0]          flags_in,
  output arm_core_pkg::word_t      result,
  output logic [3:0]               flags_out,
  output logic                     writes_result
);
  import arm_core_pkg::*;

  word_t       add_a;
  word_t       add_b;
  logic        add_cin;
  logic [32:0] sum;
  logic        overflow;
  logic        logical;

  // Adder operands, subtraction as a + ~b + 1
  always_comb begin
    add_a   = op_a;
    add_b   = op_b;
    add_cin = 1'b0;
    case (opcode)
      OP_SUB, OP_CMP: begin
        add_b   = ~op_b;
        add_cin = 1'b1;
      end
      OP_RSB: begin
        add_a   = op_b;
        add_b   = ~op_a;
        add_cin = 1'b1;
      end
      default: ;
    endcase
  end

  assign sum      = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};
  assign overflow = (add_a[31] == add_b[31]) && (sum[31] != add_a[31]);

  always_comb begin
    result        = sum[31:0];
    writes_result = 1'b1;
    logical       = 1'b1;
    case (opcode)
      OP_AND: result = op_a & op_b;
      OP_EOR: result = op_a ^ op_b;
      OP_SUB, OP_RSB, OP_ADD: logical = 1'b0;
      OP_TST: begin
        result        = op_a & op_b;
        writes_result = 1'b0;
      end
      OP_TEQ: begin
        result        = op_a ^ op_b;
        writes_result = 1'b0;
      end
      OP_CMP, OP_CMN: begin
        logical       = 1'b0;
        writes_result = 1'b0;
      end
      OP_ORR: result = op_a | op_b;
      OP_MOV: result = op_b;
      OP_BIC: result = op_a & ~op_b;
      OP_MVN: result = ~op_b;
      default: writes_result = 1'b0;  // ADC, SBC, RSC not implemented
    endcase
  end

  always_comb begin
    flags_out         = flags_in;
    flags_out[FLAG_N] = result[31];
    flags_out[FLAG_Z] = (result == 32'd0);
    if (logical) begin
      flags_out[FLAG_C] = shifter_carry;  // V untouched
    end else begin
      flags_out[FLAG_C] = sum[32];  // Not-borrow on subtract
      flags_out[FLAG_V] = overflow;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/barrel_shifter.sv ====
`default_nettype none
`timescale 1ns/100ps

module barrel_shifter (
  input  wire logic [11:0]         operand2,
  input  wire logic                imm_operand,
  input  wire arm_core_pkg::word_t rm_value,
  input  wire logic                carry_in,
  output arm_core_pkg::word_t      shifter_out,
  output logic                     shifter_carry
);
  import arm_core_pkg::*;

  logic [4:0] rot_amt;
  logic [4:0] shift_amt;
  logic [1:0] shift_type;
  logic [5:0] lsl_idx;
  word_t      imm_value;

  assign rot_amt    = {operand2[11:8], 1'b0};  // Twice the rotate field
  assign imm_value  = ror32({24'd0, operand2[7:0]}, rot_amt);
  assign shift_amt  = operand2[11:7];
  assign shift_type = operand2[6:5];
  assign lsl_idx    = 6'd32 - {1'b0, shift_amt};

  always_comb begin
    shifter_out   = rm_value;
    shifter_carry = carry_in;
    if (imm_operand) begin
      shifter_out   = imm_value;
      shifter_carry = (rot_amt != 5'd0) ? imm_value[31] : carry_in;
    end else begin
      unique case (shift_type)
        SH_LSL: begin
          if (shift_amt != 5'd0) begin  // LSL #0 passes Rm and C through
            shifter_out   = rm_value << shift_amt;
            shifter_carry = rm_value[lsl_idx[4:0]];
          end
        end
        SH_LSR: begin
          // Amount 0 encodes LSR #32
          shifter_out   = (shift_amt == 5'd0) ? 32'd0 : rm_value >> shift_amt;
          shifter_carry = (shift_amt == 5'd0) ? rm_value[31] : rm_value[shift_amt - 5'd1];
        end
        SH_ASR: begin
          if (shift_amt == 5'd0) begin  // ASR #32
            shifter_out   = {32{rm_value[31]}};
            shifter_carry = rm_value[31];
          end else begin
            shifter_out   = word_t'($signed(rm_value) >>> shift_amt);
            shifter_carry = rm_value[shift_amt - 5'd1];
          end
        end
        SH_ROR: begin
          if (shift_amt == 5'd0) begin
            shifter_out   = {carry_in, rm_value[31:1]};  // RRX
            shifter_carry = rm_value[0];
          end else begin
            shifter_out   = ror32(rm_value, shift_amt);
            shifter_carry = rm_value[shift_amt - 5'd1];
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module instr_decoder (
  input  wire arm_core_pkg::instr_u ir,
  input  wire logic [3:0]           flags,
  output logic                      cond_pass,
  output logic                      is_transfer,
  output logic                      is_load,
  output logic                      imm_operand,
  output logic                      set_flags,
  output logic                      up_offset,
  output logic [3:0]                opcode,
  output logic [3:0]                rn,
  output logic [3:0]                rd,
  output logic [3:0]                rm,
  output logic [11:0]               operand2,
  output logic [11:0]               offset12
);
  import arm_core_pkg::*;

  logic n;
  logic z;
  logic c;
  logic v;
  logic cond_ok;
  logic class_ok;

  assign n = flags[FLAG_N];
  assign z = flags[FLAG_Z];
  assign c = flags[FLAG_C];
  assign v = flags[FLAG_V];

  always_comb begin
    case (ir.dp.cond)
      COND_EQ: cond_ok = z;
      COND_NE: cond_ok = !z;
      COND_CS: cond_ok = c;
      COND_CC: cond_ok = !c;
      COND_MI: cond_ok = n;
      COND_PL: cond_ok = !n;
      COND_VS: cond_ok = v;
      COND_VC: cond_ok = !v;
      COND_HI: cond_ok = c && !z;
      COND_LS: cond_ok = !c || z;
      COND_GE: cond_ok = (n == v);
      COND_LT: cond_ok = (n != v);
      COND_GT: cond_ok = !z && (n == v);
      COND_LE: cond_ok = z || (n != v);
      COND_AL: cond_ok = 1'b1;
      default: cond_ok = 1'b0;  // NV never executes
    endcase
  end

  // Other classes run as no-ops
  assign class_ok    = (ir.dp.cls == CLASS_DP) || (ir.dp.cls == CLASS_SDT);
  assign cond_pass   = cond_ok && class_ok;

  assign is_transfer = (ir.sdt.cls == CLASS_SDT);
  assign is_load     = is_transfer && ir.sdt.l;
  assign up_offset   = ir.sdt.u;
  assign imm_operand = ir.dp.i;
  assign set_flags   = ir.dp.s && !is_transfer;

  // Transfers borrow the adder to form Rn +/- offset
  assign opcode = is_transfer ? (up_offset ? OP_ADD : OP_SUB) : ir.dp.opcode;

  assign rn       = ir.dp.rn;
  assign rd       = ir.dp.rd;
  assign rm       = ir.dp.operand2[3:0];
  assign operand2 = ir.dp.operand2;
  assign offset12 = ir.sdt.offset12;

endmodule

`default_nettype wire

// ==== verilog/arm_core_pkg.sv ====
`default_nettype none

package arm_core_pkg;

  typedef logic [31:0] word_t;

  // Data processing view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        i;
    logic [3:0]  opcode;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dp_instr_t;

  // Single data transfer view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        i;
    logic        p;
    logic        u;   // Add offset when set
    logic        b;
    logic        w;
    logic        l;   // Load when set
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset12;
  } sdt_instr_t;

  typedef union packed {
    dp_instr_t  dp;
    sdt_instr_t sdt;
  } instr_u;

  // ========================================
  // Opcodes
  // ========================================
  localparam logic [3:0] OP_AND = 4'b0000;
  localparam logic [3:0] OP_EOR = 4'b0001;
  localparam logic [3:0] OP_SUB = 4'b0010;
  localparam logic [3:0] OP_RSB = 4'b0011;
  localparam logic [3:0] OP_ADD = 4'b0100;
  localparam logic [3:0] OP_TST = 4'b1000;
  localparam logic [3:0] OP_TEQ = 4'b1001;
  localparam logic [3:0] OP_CMP = 4'b1010;
  localparam logic [3:0] OP_CMN = 4'b1011;
  localparam logic [3:0] OP_ORR = 4'b1100;
  localparam logic [3:0] OP_MOV = 4'b1101;
  localparam logic [3:0] OP_BIC = 4'b1110;
  localparam logic [3:0] OP_MVN = 4'b1111;

  // ========================================
  // Condition codes
  // ========================================
  localparam logic [3:0] COND_EQ = 4'h0;
  localparam logic [3:0] COND_NE = 4'h1;
  localparam logic [3:0] COND_CS = 4'h2;
  localparam logic [3:0] COND_CC = 4'h3;
  localparam logic [3:0] COND_MI = 4'h4;
  localparam logic [3:0] COND_PL = 4'h5;
  localparam logic [3:0] COND_VS = 4'h6;
  localparam logic [3:0] COND_VC = 4'h7;
  localparam logic [3:0] COND_HI = 4'h8;
  localparam logic [3:0] COND_LS = 4'h9;
  localparam logic [3:0] COND_GE = 4'ha;
  localparam logic [3:0] COND_LT = 4'hb;
  localparam logic [3:0] COND_GT = 4'hc;
  localparam logic [3:0] COND_LE = 4'hd;
  localparam logic [3:0] COND_AL = 4'he;

  localparam logic [1:0] SH_LSL = 2'b00;
  localparam logic [1:0] SH_LSR = 2'b01;
  localparam logic [1:0] SH_ASR = 2'b10;
  localparam logic [1:0] SH_ROR = 2'b11;

  localparam logic [1:0] CLASS_DP  = 2'b00;
  localparam logic [1:0] CLASS_SDT = 2'b01;

  // Positions within the flag nibble
  localparam int unsigned FLAG_N = 3;
  localparam int unsigned FLAG_Z = 2;
  localparam int unsigned FLAG_C = 1;
  localparam int unsigned FLAG_V = 0;

  // Rotate right, amount 0 gives x back
  function automatic word_t ror32(word_t x, logic [4:0] n);
    return (x >> n) | (x << (6'd32 - {1'b0, n}));
  endfunction

endpackage

`default_nettype wire
